// ==== gpu_top.f ====
+incdir+include
source/gpu_reg_pkg.sv
source/gpu_pixel_pkg.sv
source/gpu_regs.sv
source/fb_dma_reader.sv
source/bus_interconnect.sv
source/line_renderer.sv
source/gpu_top.sv
testbench/wb_mem_model.sv
testbench/gpu_top_tb.sv

// ==== include/gpu_macros.svh ====
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// display geometry shrunk for short runs
`define GPU_LINE_PIXELS     32
`define GPU_FIELD_LINES     8
`define GPU_RING_LINES      4
`define GPU_WORDS_PER_LINE  4

// pixel index lives in the low bits of a line memory address
`define GPU_LINE_ADDR_BITS  9
`define GPU_VID_ADDR_W      20
`define GPU_MEM_ADDR_W      24

// word offsets inside the register region
`define GPU_REG_PALETTE     0
`define GPU_REG_FB_ADDR     16
`define GPU_REG_PITCH       17
`define GPU_REG_STATUS      18

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gpu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gpu_top_tb -f gpu_top.f -o gpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/gpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

// ==== source/bus_interconnect.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module bus_interconnect
	import gpu_reg_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        cpu_cyc,
	input  logic                        cpu_stb,
	input  logic                        cpu_we,
	input  logic [24:0]                 cpu_adr,
	input  logic [31:0]                 cpu_dat_w,
	input  logic                        reg_ack,
	input  logic [31:0]                 reg_dat_r,
	input  logic                        dma_cyc,
	input  logic                        dma_stb,
	input  logic [`GPU_MEM_ADDR_W-1:0]  dma_adr,
	input  logic                        mem_ack,
	input  logic [31:0]                 mem_dat_r,
	output logic                        cpu_ack,
	output logic [31:0]                 cpu_dat_r,
	output logic                        reg_stb,
	output logic                        reg_we,
	output logic [17:0]                 reg_adr,
	output logic [31:0]                 reg_dat_w,
	output logic                        dma_ack,
	output logic [31:0]                 dma_dat_r,
	output logic                        mem_cyc,
	output logic                        mem_stb,
	output logic                        mem_we,
	output logic [`GPU_MEM_ADDR_W-1:0]  mem_adr,
	output logic [31:0]                 mem_dat_w
);

	cpu_region_t cpu_region;
	logic        cpu_owns;
	logic        dma_owns;
	logic        cpu_mem_req;
	logic        dma_req;

	assign cpu_region = (cpu_adr[23:20] == 4'h0) ? region_reg : region_mem;
	assign cpu_mem_req = cpu_cyc && cpu_stb && cpu_region == region_mem;
	assign dma_req = dma_cyc && dma_stb;

	// CPU wins when both ask and an owner keeps the bus until its ack
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_owns <= 1'b0;
			dma_owns <= 1'b0;
		end else if (cpu_owns || dma_owns) begin
			if (mem_ack) begin
				cpu_owns <= 1'b0;
				dma_owns <= 1'b0;
			end
		end else if (cpu_mem_req) begin
			cpu_owns <= 1'b1;
		end else if (dma_req) begin
			dma_owns <= 1'b1;
		end
	end

	assign reg_stb = cpu_cyc && cpu_stb && cpu_region == region_reg;
	assign reg_we = cpu_we;
	assign reg_adr = cpu_adr[19:2];
	assign reg_dat_w = cpu_dat_w;

	assign mem_cyc = (cpu_owns && cpu_cyc) || (dma_owns && dma_cyc);
	assign mem_stb = (cpu_owns && cpu_stb) || (dma_owns && dma_stb);
	assign mem_we = cpu_owns && cpu_we;
	// word address keeps the region bit, so memory starts at 0x040000
	assign mem_adr = cpu_owns ? {1'b0, cpu_adr[24:2]} : dma_adr;
	assign mem_dat_w = cpu_dat_w;

	assign cpu_ack = (cpu_region == region_reg) ? reg_ack : (cpu_owns && mem_ack);
	assign cpu_dat_r = (cpu_region == region_reg) ? reg_dat_r : mem_dat_r;
	assign dma_ack = dma_owns && mem_ack;
	assign dma_dat_r = mem_dat_r;

	// memory acks only a cycle that holds the grant
	ack_has_owner: assert property (@(posedge clk) disable iff (reset)
		mem_ack |-> (cpu_owns || dma_owns));

endmodule

// ==== source/fb_dma_reader.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module fb_dma_reader
	import gpu_pixel_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        line_start,
	input  logic [`GPU_MEM_ADDR_W-1:0]  line_base,
	input  logic                        word_take,
	input  logic                        dma_ack,
	input  logic [31:0]                 dma_dat_r,
	output logic                        dma_cyc,
	output logic                        dma_stb,
	output logic [`GPU_MEM_ADDR_W-1:0]  dma_adr,
	output logic                        word_valid,
	output pixel_word_t                 word_data
);

	localparam int CNT_W = $clog2(`GPU_WORDS_PER_LINE + 1);

	pixel_word_t      fifo_mem [2];
	logic             wr_ptr;
	logic             rd_ptr;
	logic [1:0]       count;
	logic [CNT_W-1:0] issued;
	logic             push;
	logic             more;

	assign push = dma_cyc && dma_ack;
	// room means one free slot, since at most one read is in flight
	assign more = !dma_cyc && count != 2'd2 && issued < CNT_W'(`GPU_WORDS_PER_LINE);

	always_ff @(posedge clk) begin
		if (reset) begin
			dma_cyc <= 1'b0;
			count <= 2'd0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			issued <= '0;
		end else if (line_start) begin
			// first read of the line goes out right away
			dma_cyc <= 1'b1;
			issued <= CNT_W'(1);
			count <= 2'd0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
		end else begin
			count <= count + {1'b0, push} - {1'b0, word_take};
			if (word_take)
				rd_ptr <= !rd_ptr;
			if (push) begin
				dma_cyc <= 1'b0;
				wr_ptr <= !wr_ptr;
			end else if (more) begin
				dma_cyc <= 1'b1;
				issued <= issued + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start)
			dma_adr <= line_base;
		else if (push)
			dma_adr <= dma_adr + 24'd1;
		if (push)
			fifo_mem[wr_ptr] <= dma_dat_r;
	end

	assign dma_stb = dma_cyc;
	assign word_valid = count != 2'd0;
	assign word_data = fifo_mem[rd_ptr];

	take_when_valid: assert property (@(posedge clk) disable iff (reset)
		word_take |-> word_valid);

endmodule

// ==== source/gpu_pixel_pkg.sv ====
package gpu_pixel_pkg;

	// 8 bits each of red, green, blue
	typedef logic [23:0] rgb_t;

	// one framebuffer word, either raw or as eight palette indices;
	// nib[0] sits in bits 3:0 and is the leftmost pixel
	typedef union packed {
		logic [31:0]     raw;
		logic [7:0][3:0] nib;
	} pixel_word_t;

endpackage

// ==== source/gpu_reg_pkg.sv ====
package gpu_reg_pkg;

	// register targets of the CPU register region
	typedef enum logic [2:0] {
		sel_palette,
		sel_fb_addr,
		sel_pitch,
		sel_status,
		sel_none
	} reg_sel_t;

	// address bits 23:20 all zero select the register region
	typedef enum logic {
		region_reg,
		region_mem
	} cpu_region_t;

endpackage

// ==== source/gpu_regs.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module gpu_regs
	import gpu_reg_pkg::*, gpu_pixel_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        stb,
	input  logic                        we,
	input  logic [17:0]                 adr,
	input  logic [31:0]                 dat_w,
	input  logic [`GPU_VID_ADDR_W-1:0]  curr_vid_addr,
	input  logic [3:0]                  pal_index,
	output logic                        ack,
	output logic [31:0]                 dat_r,
	output logic [`GPU_MEM_ADDR_W-1:0]  fb_addr,
	output logic [16:0]                 pitch,
	output rgb_t                        pal_color
);

	rgb_t        palette [16];
	reg_sel_t    sel;
	logic [3:0]  pal_slot;
	logic [31:0] rd_word;
	logic        take;

	// a strobe is served once, on the clock before ack
	assign take = stb && !ack;
	assign pal_slot = 4'(adr - 18'(`GPU_REG_PALETTE));

	always_comb begin
		if ((adr - 18'(`GPU_REG_PALETTE)) < 18'd16)
			sel = sel_palette;
		else if (adr == 18'(`GPU_REG_FB_ADDR))
			sel = sel_fb_addr;
		else if (adr == 18'(`GPU_REG_PITCH))
			sel = sel_pitch;
		else if (adr == 18'(`GPU_REG_STATUS))
			sel = sel_status;
		else
			sel = sel_none;
	end

	always_comb begin
		case (sel)
			sel_palette: rd_word = {8'h00, palette[pal_slot]};
			sel_fb_addr: rd_word = {8'h00, fb_addr};
			sel_pitch:   rd_word = {15'h0000, pitch};
			// scan position, in the same form the video side counts it
			sel_status:  rd_word = {8'h00, curr_vid_addr, 4'h0};
			default:     rd_word = 32'h0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			fb_addr <= 24'h040100;
			pitch <= 17'd4;
		end else begin
			ack <= take;
			if (take && we) begin
				case (sel)
					sel_fb_addr: fb_addr <= dat_w[`GPU_MEM_ADDR_W-1:0];
					sel_pitch:   pitch <= dat_w[16:0];
					default:     ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			dat_r <= rd_word;
			if (we && sel == sel_palette)
				palette[pal_slot] <= dat_w[23:0];
		end
	end

	// combinational palette lookup for the renderer
	assign pal_color = palette[pal_index];

	// the bus master holds its strobe until the ack
	stb_held: assert property (@(posedge clk) disable iff (reset) stb && !ack |=> stb);

endmodule

// ==== source/gpu_top.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module gpu_top
	import gpu_pixel_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        cpu_cyc,
	input  logic                        cpu_stb,
	input  logic                        cpu_we,
	input  logic [24:0]                 cpu_adr,
	input  logic [31:0]                 cpu_dat_w,
	output logic [31:0]                 cpu_dat_r,
	output logic                        cpu_ack,
	output logic                        mem_cyc,
	output logic                        mem_stb,
	output logic                        mem_we,
	output logic [`GPU_MEM_ADDR_W-1:0]  mem_adr,
	output logic [31:0]                 mem_dat_w,
	input  logic [31:0]                 mem_dat_r,
	input  logic                        mem_ack,
	output logic [`GPU_VID_ADDR_W-1:0]  vid_addr,
	output logic [23:0]                 vid_data,
	output logic                        vid_wen,
	input  logic [`GPU_VID_ADDR_W-1:0]  curr_vid_addr,
	input  logic                        next_field
);

	logic                        reg_stb;
	logic                        reg_we;
	logic [17:0]                 reg_adr;
	logic [31:0]                 reg_dat_w;
	logic                        reg_ack;
	logic [31:0]                 reg_dat_r;
	logic                        dma_cyc;
	logic                        dma_stb;
	logic [`GPU_MEM_ADDR_W-1:0]  dma_adr;
	logic                        dma_ack;
	logic [31:0]                 dma_dat_r;
	logic [`GPU_MEM_ADDR_W-1:0]  fb_addr;
	logic [16:0]                 pitch;
	logic [3:0]                  pal_index;
	rgb_t                        pal_color;
	logic                        line_start;
	logic [`GPU_MEM_ADDR_W-1:0]  line_base;
	logic                        word_valid;
	pixel_word_t                 word_data;
	logic                        word_take;

	bus_interconnect bus_i (
		.clk(clk), .reset(reset),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we),
		.cpu_adr(cpu_adr), .cpu_dat_w(cpu_dat_w),
		.reg_ack(reg_ack), .reg_dat_r(reg_dat_r),
		.dma_cyc(dma_cyc), .dma_stb(dma_stb), .dma_adr(dma_adr),
		.mem_ack(mem_ack), .mem_dat_r(mem_dat_r),
		.cpu_ack(cpu_ack), .cpu_dat_r(cpu_dat_r),
		.reg_stb(reg_stb), .reg_we(reg_we), .reg_adr(reg_adr), .reg_dat_w(reg_dat_w),
		.dma_ack(dma_ack), .dma_dat_r(dma_dat_r),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
		.mem_adr(mem_adr), .mem_dat_w(mem_dat_w)
	);

	gpu_regs regs_i (
		.clk(clk), .reset(reset),
		.stb(reg_stb), .we(reg_we), .adr(reg_adr), .dat_w(reg_dat_w),
		.curr_vid_addr(curr_vid_addr), .pal_index(pal_index),
		.ack(reg_ack), .dat_r(reg_dat_r),
		.fb_addr(fb_addr), .pitch(pitch), .pal_color(pal_color)
	);

	fb_dma_reader dma_i (
		.clk(clk), .reset(reset),
		.line_start(line_start), .line_base(line_base), .word_take(word_take),
		.dma_ack(dma_ack), .dma_dat_r(dma_dat_r),
		.dma_cyc(dma_cyc), .dma_stb(dma_stb), .dma_adr(dma_adr),
		.word_valid(word_valid), .word_data(word_data)
	);

	line_renderer render_i (
		.clk(clk), .reset(reset),
		.fb_addr(fb_addr), .pitch(pitch), .pal_color(pal_color),
		.word_valid(word_valid), .word_data(word_data),
		.curr_vid_addr(curr_vid_addr), .next_field(next_field),
		.pal_index(pal_index), .line_start(line_start), .line_base(line_base),
		.word_take(word_take),
		.vid_addr(vid_addr), .vid_data(vid_data), .vid_wen(vid_wen)
	);

endmodule

// ==== source/line_renderer.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module line_renderer
	import gpu_pixel_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`GPU_MEM_ADDR_W-1:0]  fb_addr,
	input  logic [16:0]                 pitch,
	input  rgb_t                        pal_color,
	input  logic                        word_valid,
	input  pixel_word_t                 word_data,
	input  logic [`GPU_VID_ADDR_W-1:0]  curr_vid_addr,
	input  logic                        next_field,
	output logic [3:0]                  pal_index,
	output logic                        line_start,
	output logic [`GPU_MEM_ADDR_W-1:0]  line_base,
	output logic                        word_take,
	output logic [`GPU_VID_ADDR_W-1:0]  vid_addr,
	output logic [23:0]                 vid_data,
	output logic                        vid_wen
);

	localparam int RING_BITS = $clog2(`GPU_RING_LINES);
	localparam int LINE_W = `GPU_VID_ADDR_W - `GPU_LINE_ADDR_BITS;

	logic [LINE_W-1:0]              wr_line;
	logic [`GPU_LINE_ADDR_BITS-1:0] wr_pixel;
	logic                           line_open;
	logic                           field_done;
	logic                           room;
	logic                           write_px;
	logic                           last_px;

	assign field_done = wr_line == LINE_W'(`GPU_FIELD_LINES);
	// the ring slot under the scan is still being displayed
	assign room = wr_line[RING_BITS-1:0] !=
		curr_vid_addr[`GPU_LINE_ADDR_BITS +: RING_BITS];
	assign write_px = !field_done && room && line_open && word_valid;
	assign last_px = wr_pixel == `GPU_LINE_ADDR_BITS'(`GPU_LINE_PIXELS - 1);

	assign pal_index = word_data.nib[wr_pixel[2:0]];
	// eighth pixel of a word frees it in the DMA buffer
	assign word_take = write_px && wr_pixel[2:0] == 3'd7;

	always_ff @(posedge clk) begin
		if (reset) begin
			// parked past the last line until the first next_field
			wr_line <= LINE_W'(`GPU_FIELD_LINES);
			wr_pixel <= '0;
			line_open <= 1'b0;
			line_start <= 1'b0;
			vid_wen <= 1'b0;
		end else begin
			line_start <= 1'b0;
			vid_wen <= write_px;
			if (field_done) begin
				if (next_field) begin
					wr_line <= '0;
					wr_pixel <= '0;
					line_open <= 1'b0;
				end
			end else if (room && !line_open) begin
				line_start <= 1'b1;
				line_open <= 1'b1;
			end else if (write_px) begin
				if (last_px) begin
					wr_line <= wr_line + LINE_W'(1);
					wr_pixel <= '0;
					line_open <= 1'b0;
				end else begin
					wr_pixel <= wr_pixel + `GPU_LINE_ADDR_BITS'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (field_done && next_field)
			line_base <= fb_addr;
		else if (write_px && last_px)
			line_base <= line_base + 24'(pitch);
		if (write_px) begin
			vid_addr <= {wr_line, wr_pixel};
			vid_data <= pal_color;
		end
	end

	// a landed write never sits in the slot the scan now shows
	ring_guard: assert property (@(posedge clk) disable iff (reset)
		vid_wen |-> vid_addr[`GPU_LINE_ADDR_BITS +: RING_BITS] !=
			curr_vid_addr[`GPU_LINE_ADDR_BITS +: RING_BITS]);

endmodule

// ==== testbench/gpu_top_tb.sv ====
`timescale 1ns/1ps
`include "gpu_macros.svh"

module gpu_top_tb
	import gpu_pixel_pkg::*, gpu_reg_pkg::*;
();

	localparam int FIELD_PIXELS = `GPU_LINE_PIXELS * `GPU_FIELD_LINES;
	// about 12 cycles per pixel worst case over five fields, plus table traffic
	localparam int CYCLE_LIMIT = 5 * FIELD_PIXELS * 12 + 4640;

	typedef struct {
		logic        we;
		logic [24:0] adr;
		logic [31:0] dat;
		logic [31:0] expect_val;
		cpu_region_t region;
	} bus_op_t;

	logic        clk;
	logic        reset;
	logic        cpu_cyc;
	logic        cpu_stb;
	logic        cpu_we;
	logic [24:0] cpu_adr;
	logic [31:0] cpu_dat_w;
	logic [31:0] cpu_dat_r;
	logic        cpu_ack;
	logic        mem_cyc;
	logic        mem_stb;
	logic        mem_we;
	logic [23:0] mem_adr;
	logic [31:0] mem_dat_w;
	logic [31:0] mem_dat_r;
	logic        mem_ack;
	logic [19:0] vid_addr;
	logic [23:0] vid_data;
	logic        vid_wen;
	logic [19:0] curr_vid_addr;
	logic        next_field;

	bus_op_t     ops[$];
	rgb_t        pal_tab [16];
	rgb_t        cap_data [FIELD_PIXELS];
	logic        cap_seen [FIELD_PIXELS];
	int          cap_count;
	int          max_line;
	logic [19:0] scan_prev;
	int          checks;
	int          errors;
	int          cycles;

	gpu_top dut_i (
		.clk(clk), .reset(reset),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we),
		.cpu_adr(cpu_adr), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack),
		.vid_addr(vid_addr), .vid_data(vid_data), .vid_wen(vid_wen),
		.curr_vid_addr(curr_vid_addr), .next_field(next_field)
	);

	wb_mem_model mem_i (
		.clk(clk), .reset(reset), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
		.adr(mem_adr), .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] word_pattern(input logic [23:0] a);
		return (32'(a) * 32'h9e3779b1) ^ {8'h00, a};
	endfunction

	function automatic logic [24:0] mem_byte(input logic [23:0] word);
		return {word[22:0], 2'b00};
	endfunction

	function automatic logic [24:0] reg_byte(input int offset);
		return 25'(offset * 4);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_fault(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic bus_cycle(input logic we, input logic [24:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		@(posedge clk);
		cpu_cyc <= 1'b1;
		cpu_stb <= 1'b1;
		cpu_we <= we;
		cpu_adr <= adr;
		cpu_dat_w <= dat;
		do
			@(negedge clk);
		while (!cpu_ack);
		rdata = cpu_dat_r;
		@(posedge clk);
		cpu_cyc <= 1'b0;
		cpu_stb <= 1'b0;
		cpu_we <= 1'b0;
	endtask

	task automatic add_op(input logic we, input logic [24:0] adr, input logic [31:0] dat,
		input logic [31:0] exp);
		bus_op_t op;
		op.we = we;
		op.adr = adr;
		op.dat = dat;
		op.expect_val = exp;
		op.region = (adr[23:20] == 4'h0) ? region_reg : region_mem;
		ops.push_back(op);
	endtask

	task automatic run_table();
		logic [31:0] rdata;
		foreach (ops[i]) begin
			bus_cycle(ops[i].we, ops[i].adr, ops[i].dat, rdata);
			if (!ops[i].we)
				check_value($sformatf("%s read %h", (ops[i].region == region_reg) ?
					"reg" : "mem", ops[i].adr), rdata, ops[i].expect_val);
		end
		ops.delete();
	endtask

	task automatic preload_field(input logic [23:0] base, input int pitch);
		logic [31:0] rdata;
		logic [23:0] a;
		for (int l = 0; l < `GPU_FIELD_LINES; l++) begin
			for (int w = 0; w < `GPU_WORDS_PER_LINE; w++) begin
				a = 24'(base + l * pitch + w);
				bus_cycle(1'b1, mem_byte(a), word_pattern(a), rdata);
			end
		end
	endtask

	task automatic set_scan(input int line);
		@(posedge clk);
		curr_vid_addr <= 20'(line) << 9;
	endtask

	task automatic start_field();
		for (int i = 0; i < FIELD_PIXELS; i++)
			cap_seen[i] = 1'b0;
		cap_count = 0;
		max_line = -1;
		@(posedge clk);
		next_field <= 1'b1;
		@(posedge clk);
		next_field <= 1'b0;
	endtask

	task automatic wait_writes(input int target);
		int waited;
		waited = 0;
		while (cap_count < target && waited < 3000) begin
			@(negedge clk);
			waited++;
		end
		if (cap_count < target)
			report_fault($sformatf("only %0d of %0d pixel writes arrived", cap_count, target));
	endtask

	// scan moves one line each time the renderer has filled the ring ahead of it
	task automatic follow_scan(input int first);
		for (int s = first; s <= `GPU_FIELD_LINES - `GPU_RING_LINES; s++) begin
			set_scan(s);
			wait_writes(`GPU_LINE_PIXELS * (s + `GPU_RING_LINES));
		end
		repeat (50) @(posedge clk);
		check_value("pixel write count", cap_count, FIELD_PIXELS);
	endtask

	task automatic check_field(input logic [23:0] base, input int pitch);
		pixel_word_t pw;
		int idx;
		for (int l = 0; l < `GPU_FIELD_LINES; l++) begin
			for (int p = 0; p < `GPU_LINE_PIXELS; p++) begin
				idx = l * `GPU_LINE_PIXELS + p;
				pw.raw = word_pattern(24'(base + l * pitch + p / 8));
				if (!cap_seen[idx])
					report_fault($sformatf("no write for line %0d pixel %0d", l, p));
				else
					check_value($sformatf("vid_data line %0d pixel %0d", l, p),
						32'(cap_data[idx]), 32'(pal_tab[pw.nib[p % 8]]));
			end
		end
	endtask

	// capture every line memory write on the falling edge
	always @(negedge clk) begin
		int line;
		int pixel;
		if (!reset && vid_wen) begin
			line = int'(vid_addr[19:9]);
			pixel = int'(vid_addr[8:0]);
			if (vid_addr[10:9] == scan_prev[10:9])
				report_fault("pixel written into the ring slot under the scan");
			if (line < `GPU_FIELD_LINES && pixel < `GPU_LINE_PIXELS) begin
				cap_data[line * `GPU_LINE_PIXELS + pixel] = vid_data;
				cap_seen[line * `GPU_LINE_PIXELS + pixel] = 1'b1;
			end else
				report_fault($sformatf("pixel write outside the field at %h", vid_addr));
			cap_count++;
			if (line > max_line)
				max_line = line;
		end
		scan_prev = curr_vid_addr;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run aborted after %0d cycles without finishing", cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] rdata;
		int errs;
		clk = 1'b0;
		reset = 1'b1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_adr = '0;
		cpu_dat_w = '0;
		curr_vid_addr = '0;
		next_field = 1'b0;
		scan_prev = '0;
		cap_count = 0;
		checks = 0;
		errors = 0;
		for (int i = 0; i < 16; i++)
			pal_tab[i] = {8'(i * 16 + 3), 8'(255 - i * 11), 8'(i * 37 + 5)};
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// register table with the scan parked on line 7
		errs = errors;
		set_scan(7);
		for (int i = 0; i < 16; i++)
			add_op(1'b1, reg_byte(`GPU_REG_PALETTE + i), {8'h00, pal_tab[i]}, 32'h0);
		add_op(1'b1, reg_byte(`GPU_REG_FB_ADDR), 32'h0004_0180, 32'h0);
		add_op(1'b1, reg_byte(`GPU_REG_PITCH), 32'd5, 32'h0);
		for (int i = 0; i < 16; i++)
			add_op(1'b0, reg_byte(`GPU_REG_PALETTE + i), 32'h0, {8'h00, pal_tab[i]});
		add_op(1'b0, reg_byte(`GPU_REG_FB_ADDR), 32'h0, 32'h0004_0180);
		add_op(1'b0, reg_byte(`GPU_REG_PITCH), 32'h0, 32'd5);
		add_op(1'b0, reg_byte(`GPU_REG_STATUS), 32'h0, 32'h0000_e000);
		add_op(1'b0, reg_byte(19), 32'h0, 32'h0);
		add_op(1'b0, reg_byte(255), 32'h0, 32'h0);
		run_table();
		end_test("register table", errs);

		errs = errors;
		for (int i = 0; i < 8; i++)
			add_op(1'b1, mem_byte(24'(24'h040010 + i)),
				word_pattern(24'(24'h040010 + i)) ^ 32'hffff0000, 32'h0);
		for (int i = 0; i < 8; i++)
			add_op(1'b0, mem_byte(24'(24'h040010 + i)), 32'h0,
				word_pattern(24'(24'h040010 + i)) ^ 32'hffff0000);
		run_table();
		for (int i = 0; i < 8; i++)
			check_value($sformatf("mem_i.mem[%0d]", 16 + i), mem_i.mem[16 + i],
				word_pattern(24'(24'h040010 + i)) ^ 32'hffff0000);
		end_test("memory pass-through", errs);

		// first field; scan parked on line 7 lets lines 0 to 2 through
		errs = errors;
		preload_field(24'h040180, 5);
		start_field();
		wait_writes(3 * `GPU_LINE_PIXELS);
		set_scan(0);
		wait_writes(4 * `GPU_LINE_PIXELS);
		repeat (200) @(posedge clk);
		check_value("writes while scan held on line 0", cap_count, 4 * `GPU_LINE_PIXELS);
		check_value("last line written while scan held", max_line, 3);
		end_test("scan back-pressure", errs);
		follow_scan(1);
		check_field(24'h040180, 5);
		end_test("field render", errs);

		// second field with CPU reads competing for memory
		errs = errors;
		bus_cycle(1'b1, reg_byte(`GPU_REG_FB_ADDR), 32'h0004_0200, rdata);
		bus_cycle(1'b1, reg_byte(`GPU_REG_PITCH), 32'd6, rdata);
		preload_field(24'h040200, 6);
		set_scan(7);
		start_field();
		for (int i = 0; i < 6; i++) begin
			bus_cycle(1'b0, mem_byte(24'(24'h040200 + i * 6)), 32'h0, rdata);
			check_value("mem read under load", rdata, word_pattern(24'(24'h040200 + i * 6)));
			bus_cycle(1'b0, mem_byte(24'(24'h040180 + i * 5)), 32'h0, rdata);
			check_value("mem read under load", rdata, word_pattern(24'(24'h040180 + i * 5)));
		end
		wait_writes(3 * `GPU_LINE_PIXELS);
		follow_scan(0);
		check_field(24'h040200, 6);
		end_test("arbitration under load", errs);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== testbench/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model (
	input  logic        clk,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [23:0] adr,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack
);

	// 64K words mapped from word address 0x040000 upward
	localparam logic [7:0] BASE_HI = 8'h04;

	logic [31:0] mem [65536];
	int          seed = 32'h95417d0b;
	logic [1:0]  delay;
	logic [1:0]  wait_cnt;
	logic        busy;
	logic        fire;
	logic        hit;

	assign hit = adr[23:16] == BASE_HI;
	assign dat_r = hit ? mem[adr[15:0]] : 32'h0;

	always @(posedge clk) begin
		fire = 1'b0;
		if (reset) begin
			ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (!busy) begin
					// 0 to 3 wait cycles per access
					delay = 2'($random(seed));
					if (delay == 2'd0)
						fire = 1'b1;
					else begin
						busy <= 1'b1;
						wait_cnt <= delay;
					end
				end else if (wait_cnt == 2'd1) begin
					fire = 1'b1;
					busy <= 1'b0;
				end else
					wait_cnt <= wait_cnt - 2'd1;
			end
			if (fire) begin
				ack <= 1'b1;
				if (we && hit)
					mem[adr[15:0]] <= dat_w;
			end
		end
	end

endmodule
